// ==== Bender.yml ====
package:
  name: core

sources:
  - include_dirs:
      - source
    files:
      - source/core_pkg.sv
      - source/register_file.sv
      - source/inst_decode.sv
      - source/execute_unit.sv
      - source/mem_port.sv
      - source/core_control.sv
      - source/core_top.sv
  - target: test
    include_dirs:
      - source
      - bench
    files:
      - bench/core_tb.sv

// ==== bench/core_tb_model.svh ====
`ifndef CORE_TB_MODEL_SVH
`define CORE_TB_MODEL_SVH

`include "core_params.svh"

core_pkg::word_t       model_regs [`CORE_NUM_REGS];
core_pkg::word_t       model_mem [MEM_WORDS];
core_pkg::word_t       model_pc;
core_pkg::word_t       exp_pc;
core_pkg::word_t       exp_wdata;
core_pkg::word_t       exp_store_addr;
core_pkg::word_t       exp_store_data;
core_pkg::byte_strobe_t exp_store_strb;
core_pkg::reg_idx_t    exp_rd;
logic                  exp_err;
logic                  exp_wen;
logic                  exp_store;

function automatic core_pkg::word_t r_type(logic [6:0] funct7, core_pkg::reg_idx_t rs2,
	core_pkg::reg_idx_t rs1, logic [2:0] funct3, core_pkg::reg_idx_t rd);
	return {funct7, 1'b0, rs2, 1'b0, rs1, funct3, 1'b0, rd, `CORE_OP_REG};
endfunction

function automatic core_pkg::word_t i_type(logic [11:0] imm, core_pkg::reg_idx_t rs1,
	logic [2:0] funct3, core_pkg::reg_idx_t rd, logic [6:0] opcode);
	return {imm, 1'b0, rs1, funct3, 1'b0, rd, opcode};
endfunction

function automatic core_pkg::word_t s_type(logic [11:0] imm, core_pkg::reg_idx_t rs2,
	core_pkg::reg_idx_t rs1, logic [2:0] funct3);
	return {imm[11:5], 1'b0, rs2, 1'b0, rs1, funct3, imm[4:0], `CORE_OP_STORE};
endfunction

function automatic core_pkg::word_t b_type(logic [12:0] offset, core_pkg::reg_idx_t rs2,
	core_pkg::reg_idx_t rs1, logic [2:0] funct3);
	return {offset[12], offset[10:5], 1'b0, rs2, 1'b0, rs1, funct3, offset[4:1], offset[11],
		`CORE_OP_BRANCH};
endfunction

function automatic core_pkg::word_t u_type(logic [19:0] upper, core_pkg::reg_idx_t rd,
	logic [6:0] opcode);
	return {upper, 1'b0, rd, opcode};
endfunction

function automatic core_pkg::word_t j_type(logic [20:0] offset, core_pkg::reg_idx_t rd);
	return {offset[20], offset[10:1], offset[11], offset[19:12], 1'b0, rd, `CORE_OP_JAL};
endfunction

// Data accesses to 0x3000..0x3fff answer with an error.
function automatic logic in_err_range(core_pkg::word_t addr);
	return addr[31:12] == 20'h00003;
endfunction

// Executes the instruction at model_pc on the architectural state.
function automatic void step_model();
	core_pkg::word_t inst;
	core_pkg::word_t a;
	core_pkg::word_t b;
	core_pkg::word_t operand;
	core_pkg::word_t imm_i;
	core_pkg::word_t imm_s;
	core_pkg::word_t imm_b;
	core_pkg::word_t imm_j;
	core_pkg::word_t addr;
	core_pkg::word_t next_pc;
	core_pkg::word_t value;
	logic [2:0]      funct3;
	logic            writes;
	inst = model_mem[model_pc[13:2]];
	funct3 = inst[14:12];
	a = model_regs[inst[18:15]];
	b = model_regs[inst[23:20]];
	imm_i = {{20{inst[31]}}, inst[31:20]};
	imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
	imm_b = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
	imm_j = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
	next_pc = model_pc + 32'd4;
	value = '0;
	writes = 1'b0;
	exp_err = 1'b0;
	exp_store = 1'b0;
	exp_rd = inst[10:7];
	case (inst[6:0])
		`CORE_OP_LUI: begin
			writes = 1'b1;
			value = {inst[31:12], 12'h000};
		end
		`CORE_OP_AUIPC: begin
			writes = 1'b1;
			value = model_pc + {inst[31:12], 12'h000};
		end
		`CORE_OP_JAL: begin
			writes = 1'b1;
			value = model_pc + 32'd4;
			next_pc = model_pc + imm_j;
		end
		`CORE_OP_JALR: begin
			writes = 1'b1;
			value = model_pc + 32'd4;
			next_pc = (a + imm_i) & ~32'd1;
		end
		`CORE_OP_BRANCH: begin
			// funct3 bit 0 turns beq into bne.
			if ((a == b) != funct3[0]) begin
				next_pc = model_pc + imm_b;
			end
		end
		`CORE_OP_LOAD: begin
			writes = 1'b1;
			addr = a + imm_i;
			if (in_err_range(addr)) begin
				exp_err = 1'b1;
			end else if (funct3 == 3'b100) begin
				value = (model_mem[addr[13:2]] >> (8 * addr[1:0])) & 32'h0000_00ff;
			end else begin
				value = model_mem[addr[13:2]];
			end
		end
		`CORE_OP_STORE: begin
			addr = a + imm_s;
			exp_store = 1'b1;
			exp_store_addr = addr & ~32'd3;
			if (funct3 == 3'b000) begin
				exp_store_data = {4{b[7:0]}};
				exp_store_strb = '0;
				exp_store_strb[addr[1:0]] = 1'b1;
			end else begin
				exp_store_data = b;
				exp_store_strb = 4'b1111;
			end
			if (in_err_range(addr)) begin
				exp_err = 1'b1;
			end else begin
				for (int lane = 0; lane < 4; lane++) begin
					if (exp_store_strb[lane]) begin
						model_mem[addr[13:2]][lane * 8 +: 8] = exp_store_data[lane * 8 +: 8];
					end
				end
			end
		end
		`CORE_OP_IMM, `CORE_OP_REG: begin
			operand = (inst[6:0] == `CORE_OP_IMM) ? imm_i : b;
			writes = 1'b1;
			case (funct3)
				3'b000: begin
					value = (inst[6:0] == `CORE_OP_REG && inst[30]) ? a - operand : a + operand;
				end
				3'b010: value = {31'b0, $signed(a) < $signed(operand)};
				3'b011: value = {31'b0, a < operand};
				3'b100: value = a ^ operand;
				3'b110: value = a | operand;
				3'b111: value = a & operand;
				default: writes = 1'b0;
			endcase
		end
		default: writes = 1'b0;
	endcase
	if (exp_err) begin
		next_pc = '0;
	end
	exp_wen = writes && (exp_rd != '0) && !exp_err;
	exp_wdata = value;
	if (exp_wen) begin
		model_regs[exp_rd] = value;
	end
	exp_pc = model_pc;
	model_pc = next_pc;
endfunction

`endif

// ==== bench/core_tb.sv ====
`timescale 1ns/1ps
`include "core_params.svh"

module core_tb;

	localparam int MEM_WORDS = 4096;
	localparam int RESET_CYCLES = 10;
	localparam int BODY_LEN = 60;
	localparam int NUM_RETIRE = 200;
	localparam int TIMEOUT_CYCLES = RESET_CYCLES + NUM_RETIRE * 13 * 3 / 2;

	logic                   clock;
	logic                   reset;
	logic                   mem_req;
	logic                   mem_we;
	core_pkg::word_t        mem_addr;
	core_pkg::word_t        mem_wdata;
	core_pkg::byte_strobe_t mem_wstrb;
	logic                   mem_ack;
	core_pkg::word_t        mem_rdata;
	logic                   mem_err;
	logic                   retire;
	core_pkg::word_t        retire_pc;
	logic                   retire_err;
	logic                   retire_wen;
	core_pkg::reg_idx_t     retire_rd;
	core_pkg::word_t        retire_wdata;

	core_pkg::word_t        memory [MEM_WORDS];
	core_pkg::word_t        store_addr_q [$];
	core_pkg::word_t        store_data_q [$];
	core_pkg::byte_strobe_t store_strb_q [$];
	integer                 seed = 89324;
	int                     errors = 0;
	int                     checks = 0;
	int                     retired = 0;
	int                     cycles = 0;

	`include "core_tb_model.svh"

	core_top u_dut (
		.clock        (clock),
		.reset        (reset),
		.mem_req      (mem_req),
		.mem_we       (mem_we),
		.mem_addr     (mem_addr),
		.mem_wdata    (mem_wdata),
		.mem_wstrb    (mem_wstrb),
		.mem_ack      (mem_ack),
		.mem_rdata    (mem_rdata),
		.mem_err      (mem_err),
		.retire       (retire),
		.retire_pc    (retire_pc),
		.retire_err   (retire_err),
		.retire_wen   (retire_wen),
		.retire_rd    (retire_rd),
		.retire_wdata (retire_wdata)
	);

	function automatic int pick(int n);
		return $unsigned($random(seed)) % n;
	endfunction

	function automatic core_pkg::word_t fill_pattern(core_pkg::word_t addr);
		return {addr[15:0] ^ 16'h6b2d, ~addr[15:0] + addr[31:16]};
	endfunction

	function automatic logic [2:0] alu_funct3();
		logic [2:0] codes [6] = '{3'b000, 3'b010, 3'b011, 3'b100, 3'b110, 3'b111};
		return codes[pick(6)];
	endfunction

	task automatic check_word(input string name, input core_pkg::word_t got,
		input core_pkg::word_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERR %0t %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_reg(input string name, input core_pkg::reg_idx_t got,
		input core_pkg::reg_idx_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERR %0t %s got %0d expected %0d", $time, name, got, exp);
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERR %0t %s got %b expected %b", $time, name, got, exp);
		end
	endtask

	task automatic check_strobe(input string name, input core_pkg::byte_strobe_t got,
		input core_pkg::byte_strobe_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERR %0t %s got %b expected %b", $time, name, got, exp);
		end
	endtask

	// Register setup, a random body with forward control flow, then a faulting load.
	task automatic build_program();
		int                 pos;
		int                 end_pos;
		int                 hop;
		core_pkg::reg_idx_t rd;
		core_pkg::reg_idx_t rs1;
		core_pkg::reg_idx_t rs2;
		logic [2:0]         funct3;
		for (int i = 0; i < MEM_WORDS; i++) begin
			memory[i] = fill_pattern(i << 2);
		end
		pos = 0;
		for (int r = 1; r < 14; r++) begin
			memory[pos] = i_type(pick(4096), 4'd0, 3'b000, r, `CORE_OP_IMM);
			pos++;
		end
		// x14 points at the error range, x15 at the data area.
		memory[pos] = u_type(20'h00003, 4'd14, `CORE_OP_LUI);
		pos++;
		memory[pos] = u_type(20'h00001, 4'd15, `CORE_OP_LUI);
		pos++;
		end_pos = pos + BODY_LEN;
		while (pos < end_pos) begin
			rd = pick(14);
			rs1 = pick(16);
			rs2 = pick(16);
			hop = 1 + pick(3);
			if (hop > end_pos - pos) begin
				hop = end_pos - pos;
			end
			case (pick(10))
				0, 1: begin
					funct3 = alu_funct3();
					memory[pos] = r_type((funct3 == 3'b000 && pick(2)) ? 7'b0100000 : 7'b0,
						rs2, rs1, funct3, rd);
				end
				2: memory[pos] = i_type(pick(4096), rs1, alu_funct3(), rd, `CORE_OP_IMM);
				3: memory[pos] = u_type(pick(1 << 20), rd, pick(2) ? `CORE_OP_LUI : `CORE_OP_AUIPC);
				4: begin
					if (pick(2)) begin
						rs2 = rs1;
					end
					memory[pos] = b_type(hop * 4, rs2, rs1, pick(2));
				end
				5: memory[pos] = j_type(hop * 4, rd);
				// Odd targets check that jalr clears bit zero.
				6: memory[pos] = i_type((pos + hop) * 4 + pick(2), 4'd0, 3'b000, rd, `CORE_OP_JALR);
				7: begin
					if (pick(2)) begin
						memory[pos] = i_type(4 * pick(64), 4'd15, 3'b010, rd, `CORE_OP_LOAD);
					end else begin
						memory[pos] = i_type(pick(256), 4'd15, 3'b100, rd, `CORE_OP_LOAD);
					end
				end
				8: begin
					if (pick(2)) begin
						memory[pos] = s_type(4 * pick(64), rs2, 4'd15, 3'b010);
					end else begin
						memory[pos] = s_type(pick(256), rs2, 4'd15, 3'b000);
					end
				end
				// Shift encodings retire as no-ops.
				default: memory[pos] = i_type(pick(32), rs1, 3'b001, rd, `CORE_OP_IMM);
			endcase
			pos++;
		end
		memory[pos] = i_type(4 * pick(512), 4'd14, 3'b010, pick(14), `CORE_OP_LOAD);
	endtask

	initial begin
		clock = 1'b0;
		forever #4 clock = ~clock;
	end

	// Memory with 1 to 4 cycles of latency.
	initial begin : memory_model
		core_pkg::word_t        addr;
		core_pkg::word_t        wdata;
		core_pkg::byte_strobe_t wstrb;
		logic                   we;
		logic                   first;
		int                     latency;
		mem_ack = 1'b0;
		mem_err = 1'b0;
		mem_rdata = '0;
		first = 1'b1;
		forever begin
			@(negedge clock);
			if (!reset && mem_req === 1'b1) begin
				addr = mem_addr;
				we = mem_we;
				wdata = mem_wdata;
				wstrb = mem_wstrb;
				if (first) begin
					check_word("mem_addr", addr, `CORE_RESET_PC);
					check_flag("mem_we", we, 1'b0);
					first = 1'b0;
				end
				if (we) begin
					store_addr_q.push_back(addr);
					store_data_q.push_back(wdata);
					store_strb_q.push_back(wstrb);
				end
				latency = 1 + pick(4);
				// No new request may start before the ack.
				repeat (latency - 1) begin
					@(negedge clock);
					check_flag("mem_req", mem_req, 1'b0);
				end
				@(posedge clock);
				#1;
				mem_ack = 1'b1;
				if (in_err_range(addr)) begin
					mem_err = 1'b1;
					mem_rdata = '0;
				end else begin
					mem_rdata = memory[addr[13:2]];
					for (int lane = 0; lane < 4; lane++) begin
						if (we && wstrb[lane]) begin
							memory[addr[13:2]][lane * 8 +: 8] = wdata[lane * 8 +: 8];
						end
					end
				end
				@(negedge clock);
				check_flag("mem_req", mem_req, 1'b0);
				@(posedge clock);
				#1;
				mem_ack = 1'b0;
				mem_err = 1'b0;
			end
		end
	end

	initial begin : compare_retire
		forever begin
			@(negedge clock);
			if (!reset && retire === 1'b1) begin
				step_model();
				check_word("retire_pc", retire_pc, exp_pc);
				check_flag("retire_err", retire_err, exp_err);
				check_flag("retire_wen", retire_wen, exp_wen);
				if (exp_wen) begin
					check_reg("retire_rd", retire_rd, exp_rd);
					check_word("retire_wdata", retire_wdata, exp_wdata);
				end
				if (exp_store && store_addr_q.size() == 0) begin
					errors++;
					$display("store at pc %h made no write request", exp_pc);
				end else if (exp_store) begin
					check_word("mem_addr", store_addr_q.pop_front(), exp_store_addr);
					check_word("mem_wdata", store_data_q.pop_front(), exp_store_data);
					check_strobe("mem_wstrb", store_strb_q.pop_front(), exp_store_strb);
				end
				if (store_addr_q.size() != 0) begin
					errors++;
					$display("write request seen for the non-store at pc %h", exp_pc);
					store_addr_q.delete();
					store_data_q.delete();
					store_strb_q.delete();
				end
				retired++;
			end
		end
	end

	initial begin : watchdog
		while (cycles < TIMEOUT_CYCLES) begin
			@(posedge clock);
			cycles++;
		end
		$display("timeout after %0d cycles with %0d of %0d instructions retired",
			cycles, retired, NUM_RETIRE);
		$display("tests failed");
		$finish;
	end

	initial begin
		reset = 1'b1;
		build_program();
		for (int i = 0; i < MEM_WORDS; i++) begin
			model_mem[i] = memory[i];
		end
		for (int r = 0; r < `CORE_NUM_REGS; r++) begin
			model_regs[r] = '0;
		end
		model_pc = `CORE_RESET_PC;
		repeat (RESET_CYCLES) @(posedge clock);
		#1;
		check_flag("mem_req", mem_req, 1'b0);
		check_flag("retire", retire, 1'b0);
		reset = 1'b0;
		wait (retired >= NUM_RETIRE);
		repeat (2) @(posedge clock);
		$display("errors %0d checks %0d retired %0d", errors, checks, retired);
		if (errors == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule

// ==== filelist.f ====
+incdir+source
+incdir+bench
source/core_pkg.sv
source/register_file.sv
source/inst_decode.sv
source/execute_unit.sv
source/mem_port.sv
source/core_control.sv
source/core_top.sv
bench/core_tb.sv

// ==== source/core_control.sv ====
`timescale 1ns/1ps
`include "core_params.svh"

module core_control (
	input  logic                  clock,
	input  logic                  reset,
	input  core_pkg::op_class_t   op_class,
	input  core_pkg::reg_idx_t    rd,
	input  logic                  branch_taken,
	input  core_pkg::word_t       jump_target,
	input  core_pkg::word_t       alu_result,
	input  core_pkg::word_t       load_value,
	input  logic                  access_done,
	input  logic                  access_err,
	output logic                  fetch_start,
	output logic                  data_start,
	output logic                  reg_wen,
	output core_pkg::reg_idx_t    reg_waddr,
	output core_pkg::word_t       reg_wdata,
	output core_pkg::word_t       pc,
	output logic                  retire,
	output logic                  retire_wen,
	output logic                  retire_err,
	output core_pkg::reg_idx_t    retire_rd,
	output core_pkg::word_t       retire_pc,
	output core_pkg::word_t       retire_wdata
);

	core_pkg::ctrl_state_t state;
	core_pkg::ctrl_state_t state_next;
	logic                  err;
	logic                  is_jump;
	logic                  is_mem;
	logic                  writes_rd;
	core_pkg::word_t       pc_plus4;
	core_pkg::word_t       pc_next;

	assign is_jump = (op_class == core_pkg::CLASS_JAL) || (op_class == core_pkg::CLASS_JALR);
	assign is_mem = (op_class == core_pkg::CLASS_LOAD) || (op_class == core_pkg::CLASS_STORE);
	assign writes_rd = is_jump || (op_class == core_pkg::CLASS_ALU) ||
		(op_class == core_pkg::CLASS_LOAD);
	assign pc_plus4 = pc + 32'd4;

	always_comb begin
		state_next = state;
		case (state)
			core_pkg::STATE_FETCH: state_next = core_pkg::STATE_WAIT_FETCH;
			core_pkg::STATE_WAIT_FETCH: begin
				// A failed fetch has no instruction to execute.
				if (access_done) begin
					state_next = access_err ? core_pkg::STATE_WRITEBACK : core_pkg::STATE_EXECUTE;
				end
			end
			core_pkg::STATE_EXECUTE: begin
				state_next = is_mem ? core_pkg::STATE_MEMORY : core_pkg::STATE_WRITEBACK;
			end
			core_pkg::STATE_MEMORY: state_next = core_pkg::STATE_WAIT_MEMORY;
			core_pkg::STATE_WAIT_MEMORY: begin
				if (access_done) begin
					state_next = core_pkg::STATE_WRITEBACK;
				end
			end
			default: state_next = core_pkg::STATE_FETCH;
		endcase
	end

	always_comb begin
		if (err) begin
			pc_next = '0;
		end else if (is_jump || branch_taken) begin
			pc_next = jump_target;
		end else begin
			pc_next = pc_plus4;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= core_pkg::STATE_FETCH;
			pc <= `CORE_RESET_PC;
			err <= 1'b0;
		end else begin
			state <= state_next;
			// Sticky for the rest of the instruction.
			if (state == core_pkg::STATE_FETCH) begin
				err <= 1'b0;
			end else if (access_done && access_err) begin
				err <= 1'b1;
			end
			if (state == core_pkg::STATE_WRITEBACK) begin
				pc <= pc_next;
			end
		end
	end

	assign fetch_start = (state == core_pkg::STATE_FETCH);
	assign data_start = (state == core_pkg::STATE_MEMORY);

	assign reg_wen = (state == core_pkg::STATE_WRITEBACK) && writes_rd && (rd != '0) && !err;
	assign reg_waddr = rd;
	assign reg_wdata = (op_class == core_pkg::CLASS_LOAD) ? load_value :
		is_jump ? pc_plus4 : alu_result;

	assign retire = (state == core_pkg::STATE_WRITEBACK);
	assign retire_wen = reg_wen;
	assign retire_err = err;
	assign retire_rd = rd;
	assign retire_pc = pc;
	assign retire_wdata = reg_wdata;

endmodule

// ==== source/core_params.svh ====
`ifndef CORE_PARAMS_SVH
`define CORE_PARAMS_SVH

`define CORE_RESET_PC   32'h0000_0000
`define CORE_NUM_REGS   16

// RV32 base opcodes.
`define CORE_OP_LUI     7'b0110111
`define CORE_OP_AUIPC   7'b0010111
`define CORE_OP_JAL     7'b1101111
`define CORE_OP_JALR    7'b1100111
`define CORE_OP_BRANCH  7'b1100011
`define CORE_OP_LOAD    7'b0000011
`define CORE_OP_STORE   7'b0100011
`define CORE_OP_IMM     7'b0010011
`define CORE_OP_REG     7'b0110011

`endif

// ==== source/core_pkg.sv ====
package core_pkg;

	typedef logic [31:0] word_t;
	typedef logic [3:0]  reg_idx_t;
	typedef logic [3:0]  byte_strobe_t;

	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SLT,
		ALU_SLTU,
		ALU_PASS_B
	} alu_op_t;

	// Anything not listed retires as a no-op.
	typedef enum logic [2:0] {
		CLASS_ALU,
		CLASS_LOAD,
		CLASS_STORE,
		CLASS_BRANCH,
		CLASS_JAL,
		CLASS_JALR,
		CLASS_NONE
	} op_class_t;

	typedef enum logic [2:0] {
		STATE_FETCH,
		STATE_WAIT_FETCH,
		STATE_EXECUTE,
		STATE_MEMORY,
		STATE_WAIT_MEMORY,
		STATE_WRITEBACK
	} ctrl_state_t;

endpackage

// ==== source/core_top.sv ====
`timescale 1ns/1ps

module core_top (
	input  logic                    clock,
	input  logic                    reset,
	output logic                    mem_req,
	output logic                    mem_we,
	output core_pkg::word_t         mem_addr,
	output core_pkg::word_t         mem_wdata,
	output core_pkg::byte_strobe_t  mem_wstrb,
	input  logic                    mem_ack,
	input  core_pkg::word_t         mem_rdata,
	input  logic                    mem_err,
	output logic                    retire,
	output core_pkg::word_t         retire_pc,
	output logic                    retire_err,
	output logic                    retire_wen,
	output core_pkg::reg_idx_t      retire_rd,
	output core_pkg::word_t         retire_wdata
);

	core_pkg::word_t     pc;
	core_pkg::word_t     inst;
	core_pkg::word_t     load_value;
	core_pkg::word_t     imm;
	core_pkg::word_t     src1;
	core_pkg::word_t     src2;
	core_pkg::word_t     alu_result;
	core_pkg::word_t     jump_target;
	core_pkg::word_t     reg_wdata;
	core_pkg::reg_idx_t  rs1;
	core_pkg::reg_idx_t  rs2;
	core_pkg::reg_idx_t  rd;
	core_pkg::reg_idx_t  reg_waddr;
	core_pkg::alu_op_t   alu_op;
	core_pkg::op_class_t op_class;
	logic                use_imm;
	logic                use_pc;
	logic                is_byte;
	logic                is_store;
	logic                is_unsigned_branch;
	logic                branch_taken;
	logic                fetch_start;
	logic                data_start;
	logic                access_done;
	logic                access_err;
	logic                reg_wen;

	assign is_store = (op_class == core_pkg::CLASS_STORE);

	core_control u_control (
		.clock        (clock),
		.reset        (reset),
		.op_class     (op_class),
		.rd           (rd),
		.branch_taken (branch_taken),
		.jump_target  (jump_target),
		.alu_result   (alu_result),
		.load_value   (load_value),
		.access_done  (access_done),
		.access_err   (access_err),
		.fetch_start  (fetch_start),
		.data_start   (data_start),
		.reg_wen      (reg_wen),
		.reg_waddr    (reg_waddr),
		.reg_wdata    (reg_wdata),
		.pc           (pc),
		.retire       (retire),
		.retire_wen   (retire_wen),
		.retire_err   (retire_err),
		.retire_rd    (retire_rd),
		.retire_pc    (retire_pc),
		.retire_wdata (retire_wdata)
	);

	inst_decode u_decode (
		.inst               (inst),
		.rs1                (rs1),
		.rs2                (rs2),
		.rd                 (rd),
		.imm                (imm),
		.alu_op             (alu_op),
		.op_class           (op_class),
		.use_imm            (use_imm),
		.use_pc             (use_pc),
		.is_byte            (is_byte),
		.is_unsigned_branch (is_unsigned_branch)
	);

	execute_unit u_execute (
		.pc                 (pc),
		.src1               (src1),
		.src2               (src2),
		.imm                (imm),
		.alu_op             (alu_op),
		.op_class           (op_class),
		.use_imm            (use_imm),
		.use_pc             (use_pc),
		.is_unsigned_branch (is_unsigned_branch),
		.alu_result         (alu_result),
		.jump_target        (jump_target),
		.branch_taken       (branch_taken)
	);

	mem_port u_mem_port (
		.clock       (clock),
		.reset       (reset),
		.fetch_start (fetch_start),
		.data_start  (data_start),
		.is_byte     (is_byte),
		.is_store    (is_store),
		.pc          (pc),
		.address     (alu_result),
		.store_data  (src2),
		.mem_req     (mem_req),
		.mem_we      (mem_we),
		.mem_addr    (mem_addr),
		.mem_wdata   (mem_wdata),
		.mem_wstrb   (mem_wstrb),
		.mem_ack     (mem_ack),
		.mem_err     (mem_err),
		.mem_rdata   (mem_rdata),
		.inst        (inst),
		.load_value  (load_value),
		.access_done (access_done),
		.access_err  (access_err)
	);

	register_file u_regs (
		.clock  (clock),
		.raddr1 (rs1),
		.raddr2 (rs2),
		.waddr  (reg_waddr),
		.wen    (reg_wen),
		.wdata  (reg_wdata),
		.rdata1 (src1),
		.rdata2 (src2)
	);

endmodule

// ==== source/execute_unit.sv ====
`timescale 1ns/1ps

module execute_unit (
	input  core_pkg::word_t      pc,
	input  core_pkg::word_t      src1,
	input  core_pkg::word_t      src2,
	input  core_pkg::word_t      imm,
	input  core_pkg::alu_op_t    alu_op,
	input  core_pkg::op_class_t  op_class,
	input  logic                 use_imm,
	input  logic                 use_pc,
	input  logic                 is_unsigned_branch,
	output core_pkg::word_t      alu_result,
	output core_pkg::word_t      jump_target,
	output logic                 branch_taken
);

	core_pkg::word_t operand_a;
	core_pkg::word_t operand_b;
	core_pkg::word_t pc_offset;

	assign operand_a = use_pc ? pc : src1;
	assign operand_b = use_imm ? imm : src2;

	// Also the data address for loads and stores.
	always_comb begin
		case (alu_op)
			core_pkg::ALU_ADD: alu_result = operand_a + operand_b;
			core_pkg::ALU_SUB: alu_result = operand_a - operand_b;
			core_pkg::ALU_AND: alu_result = operand_a & operand_b;
			core_pkg::ALU_OR: alu_result = operand_a | operand_b;
			core_pkg::ALU_XOR: alu_result = operand_a ^ operand_b;
			core_pkg::ALU_SLT: begin
				alu_result = {31'b0, $signed(operand_a) < $signed(operand_b)};
			end
			core_pkg::ALU_SLTU: alu_result = {31'b0, operand_a < operand_b};
			default: alu_result = operand_b;
		endcase
	end

	assign pc_offset = pc + imm;

	// jalr goes through the adder as src1 plus imm.
	assign jump_target = (op_class == core_pkg::CLASS_JALR) ? {alu_result[31:1], 1'b0} :
		pc_offset;

	assign branch_taken = (op_class == core_pkg::CLASS_BRANCH) &&
		((src1 == src2) ^ is_unsigned_branch);

endmodule

// ==== source/inst_decode.sv ====
`timescale 1ns/1ps
`include "core_params.svh"

module inst_decode (
	input  core_pkg::word_t      inst,
	output core_pkg::reg_idx_t   rs1,
	output core_pkg::reg_idx_t   rs2,
	output core_pkg::reg_idx_t   rd,
	output core_pkg::word_t      imm,
	output core_pkg::alu_op_t    alu_op,
	output core_pkg::op_class_t  op_class,
	output logic                 use_imm,
	output logic                 use_pc,
	output logic                 is_byte,
	output logic                 is_unsigned_branch
);

	logic [6:0]      opcode;
	logic [2:0]      funct3;
	logic            funct7_alt;
	core_pkg::word_t imm_i;
	core_pkg::word_t imm_s;
	core_pkg::word_t imm_b;
	core_pkg::word_t imm_u;
	core_pkg::word_t imm_j;

	assign opcode = inst[6:0];
	assign funct3 = inst[14:12];
	assign funct7_alt = inst[30];

	// Only sixteen registers, so the top bit of each field is ignored.
	assign rd = inst[10:7];
	assign rs1 = inst[18:15];
	assign rs2 = inst[23:20];

	assign imm_i = {{20{inst[31]}}, inst[31:20]};
	assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
	assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
	assign imm_u = {inst[31:12], 12'h000};
	assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

	// Selects bne over beq.
	assign is_unsigned_branch = funct3[0];

	always_comb begin
		imm = imm_i;
		alu_op = core_pkg::ALU_ADD;
		op_class = core_pkg::CLASS_NONE;
		use_imm = 1'b1;
		use_pc = 1'b0;
		is_byte = 1'b0;
		case (opcode)
			`CORE_OP_LUI: begin
				op_class = core_pkg::CLASS_ALU;
				alu_op = core_pkg::ALU_PASS_B;
				imm = imm_u;
			end
			`CORE_OP_AUIPC: begin
				op_class = core_pkg::CLASS_ALU;
				use_pc = 1'b1;
				imm = imm_u;
			end
			`CORE_OP_JAL: begin
				op_class = core_pkg::CLASS_JAL;
				imm = imm_j;
			end
			`CORE_OP_JALR: op_class = core_pkg::CLASS_JALR;
			`CORE_OP_BRANCH: begin
				op_class = core_pkg::CLASS_BRANCH;
				use_imm = 1'b0;
				imm = imm_b;
			end
			`CORE_OP_LOAD: begin
				op_class = core_pkg::CLASS_LOAD;
				is_byte = (funct3 == 3'b100);
			end
			`CORE_OP_STORE: begin
				op_class = core_pkg::CLASS_STORE;
				is_byte = (funct3 == 3'b000);
				imm = imm_s;
			end
			`CORE_OP_IMM, `CORE_OP_REG: begin
				op_class = core_pkg::CLASS_ALU;
				use_imm = (opcode == `CORE_OP_IMM);
				case (funct3)
					3'b000: begin
						alu_op = (!use_imm && funct7_alt) ? core_pkg::ALU_SUB : core_pkg::ALU_ADD;
					end
					3'b010: alu_op = core_pkg::ALU_SLT;
					3'b011: alu_op = core_pkg::ALU_SLTU;
					3'b100: alu_op = core_pkg::ALU_XOR;
					3'b110: alu_op = core_pkg::ALU_OR;
					3'b111: alu_op = core_pkg::ALU_AND;
					// Shifts are not supported.
					default: op_class = core_pkg::CLASS_NONE;
				endcase
			end
			default: op_class = core_pkg::CLASS_NONE;
		endcase
	end

endmodule

// ==== source/mem_port.sv ====
`timescale 1ns/1ps

module mem_port (
	input  logic                    clock,
	input  logic                    reset,
	input  logic                    fetch_start,
	input  logic                    data_start,
	input  logic                    is_byte,
	input  logic                    is_store,
	input  core_pkg::word_t         pc,
	input  core_pkg::word_t         address,
	input  core_pkg::word_t         store_data,
	output logic                    mem_req,
	output logic                    mem_we,
	output core_pkg::word_t         mem_addr,
	output core_pkg::word_t         mem_wdata,
	output core_pkg::byte_strobe_t  mem_wstrb,
	input  logic                    mem_ack,
	input  logic                    mem_err,
	input  core_pkg::word_t         mem_rdata,
	output core_pkg::word_t         inst,
	output core_pkg::word_t         load_value,
	output logic                    access_done,
	output logic                    access_err
);

	logic            pending_fetch;
	logic            pending_byte;
	logic [1:0]      byte_offset;
	core_pkg::word_t shifted;
	core_pkg::word_t lane_data;

	always_ff @(posedge clock) begin
		if (reset) begin
			mem_req <= 1'b0;
		end else begin
			mem_req <= fetch_start || data_start;
		end
	end

	always_ff @(posedge clock) begin
		if (fetch_start) begin
			mem_we <= 1'b0;
			mem_addr <= {pc[31:2], 2'b00};
			mem_wdata <= '0;
			mem_wstrb <= 4'b1111;
			pending_fetch <= 1'b1;
			pending_byte <= 1'b0;
			byte_offset <= 2'b00;
		end else if (data_start) begin
			mem_we <= is_store;
			mem_addr <= {address[31:2], 2'b00};
			// Byte stores put the byte on every lane.
			mem_wdata <= is_byte ? {4{store_data[7:0]}} : store_data;
			mem_wstrb <= is_byte ? (4'b0001 << address[1:0]) : 4'b1111;
			pending_fetch <= 1'b0;
			pending_byte <= is_byte;
			byte_offset <= address[1:0];
		end
		if (mem_ack && !mem_err) begin
			if (pending_fetch) begin
				inst <= mem_rdata;
			end else begin
				load_value <= lane_data;
			end
		end
	end

	// lbu zero-extends the addressed byte.
	assign shifted = mem_rdata >> {byte_offset, 3'b000};
	assign lane_data = pending_byte ? {24'h000000, shifted[7:0]} : mem_rdata;

	assign access_done = mem_ack;
	assign access_err = mem_err;

endmodule

// ==== source/register_file.sv ====
`timescale 1ns/1ps
`include "core_params.svh"

module register_file (
	input  logic                clock,
	input  core_pkg::reg_idx_t  raddr1,
	input  core_pkg::reg_idx_t  raddr2,
	input  core_pkg::reg_idx_t  waddr,
	input  logic                wen,
	input  core_pkg::word_t     wdata,
	output core_pkg::word_t     rdata1,
	output core_pkg::word_t     rdata2
);

	core_pkg::word_t regs [`CORE_NUM_REGS];

	always_ff @(posedge clock) begin
		if (wen && (waddr != '0)) begin
			regs[waddr] <= wdata;
		end
	end

	// x0 is hardwired.
	assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
	assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule
